// File: colmix_pkg.sv
// ----------------------------------------
// widths fixed here; palette address layout
// follows the char > obj > scroll priority rule
// ----------------------------------------
package colmix_pkg;

    localparam int colour_w     = 4; // bits per colour channel
    localparam int pal_addr_w   = 8; // palette PROM address
    localparam int num_channels = 3; // red, green, blue

    // pixels from the three layer generators, one set per pixel time
    typedef struct packed {
        logic [3:0] char_pxl; // all ones = transparent
        logic [5:0] scr_pxl;  // all ones = transparent
        logic [3:0] obj_pxl;  // all ones = transparent
        logic       bank;     // colour bank strap
    } layer_pxl_t;

    // debug layer enables
    typedef struct packed {
        logic char_en;
        logic scr_en;
        logic obj_en;
    } layer_en_t;

    // scroll winner, low bits carry the full scroll code
    typedef struct packed {
        logic                  char_opaque; // raw opacity, enables ignored
        logic                  obj_opaque;
        logic [pal_addr_w-3:0] scr;
    } scr_view_t;

    // char or object winner
    // char  -> {bank, 0, colour}
    // obj   -> {0, bank, colour}
    typedef struct packed {
        logic          char_opaque;
        logic          obj_opaque;
        logic          char_bank;  // bank bit when a character wins
        logic          obj_bank;   // bank bit when an object wins
        logic [3:0]    colour;
    } spr_view_t;

    // one palette address word, decoded by winner type
    typedef union packed {
        scr_view_t scr_v;
        spr_view_t spr_v;
    } pal_addr_u;

    typedef struct packed {
        logic [colour_w-1:0] r;
        logic [colour_w-1:0] g;
        logic [colour_w-1:0] b;
    } rgb_t;

endpackage

// File: pixel_priority.sv
// ----------------------------------------
// inputs sampled on cen only; address held at
// zero while either blank is high
// ----------------------------------------
`timescale 1ns/1ps

module pixel_priority (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cen,      // pixel clock enable
    input  colmix_pkg::layer_pxl_t pxl,
    input  colmix_pkg::layer_en_t  layer_en, // debug hides
    input  logic                  hblank,
    input  logic                  vblank,
    output colmix_pkg::pal_addr_u  pal_addr,
    output logic                  active    // not blanking, same tick as pal_addr
);

    logic                 char_opaque;
    logic                 obj_opaque;
    logic                 char_vis;
    logic                 obj_vis;
    colmix_pkg::pal_addr_u addr_nx;

    // all-ones code is see-through
    assign char_opaque = ~&pxl.char_pxl;
    assign obj_opaque  = ~&pxl.obj_pxl;

    assign char_vis = char_opaque & layer_en.char_en;
    assign obj_vis  = obj_opaque  & layer_en.obj_en;

    always_comb begin
        addr_nx = '0;
        if (char_vis) begin
            // characters on top
            addr_nx.spr_v.char_bank = pxl.bank;
            addr_nx.spr_v.obj_bank  = 1'b0;
            addr_nx.spr_v.colour    = pxl.char_pxl;
        end else if (obj_vis) begin
            addr_nx.spr_v.char_bank = 1'b0;
            addr_nx.spr_v.obj_bank  = pxl.bank; // bank shifted down one bit
            addr_nx.spr_v.colour    = pxl.obj_pxl;
        end else begin
            // scroll at the back, disabled scroll reads the all-ones entry
            addr_nx.scr_v.scr = layer_en.scr_en ? pxl.scr_pxl : '1;
        end
        // flags sit in the same two bits in both views
        addr_nx.scr_v.char_opaque = char_opaque;
        addr_nx.scr_v.obj_opaque  = obj_opaque;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr <= '0;
            active   <= 1'b0;
        end else if (cen) begin
            active <= ~(hblank | vblank);
            if (hblank || vblank)
                pal_addr <= '0; // blank reads entry 0
            else
                pal_addr <= addr_nx;
        end
    end

    // downstream relies on entry 0 being read during blanking
    addr_zero_when_blank: assert property (
        @(posedge clk) disable iff (reset)
        !active |-> (pal_addr == '0)
    );

endmodule

// File: palette_prom.sv
// ----------------------------------------
// contents undefined until written; no reset
// read on same edge as write returns old data
// ----------------------------------------
`timescale 1ns/1ps

module palette_prom (
    input  logic                                clk,
    input  logic                                cen,
    input  colmix_pkg::pal_addr_u                rd_addr,
    input  logic [colmix_pkg::pal_addr_w-1:0]   wr_addr,
    input  logic [colmix_pkg::colour_w-1:0]     wr_data,
    input  logic                                we,      // ignores cen
    output logic [colmix_pkg::colour_w-1:0]     q
);

    localparam int depth = 2 ** colmix_pkg::pal_addr_w;

    // one colour channel of the palette
    logic [colmix_pkg::colour_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we)
            mem[wr_addr] <= wr_data; // load port, any clk edge
    end

    // read register, advances with the pixel clock
    always_ff @(posedge clk) begin
        if (cen)
            q <= mem[rd_addr];
    end

    // loader must present clean address and data while strobing
    wr_no_unknown: assert property (
        @(posedge clk)
        we |-> !$isunknown({wr_addr, wr_data})
    );

endmodule

// File: video_out.sv
// ----------------------------------------
// one-tick delay on active matches the PROM
// read register
// ----------------------------------------
`timescale 1ns/1ps

module video_out (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cen,
    input  logic [colmix_pkg::colour_w-1:0] chan [colmix_pkg::num_channels],
    input  logic                            active, // from priority stage
    output colmix_pkg::rgb_t                 rgb,
    output logic                            de
);

    logic active_d; // lines up with PROM q

    always_ff @(posedge clk) begin
        if (reset) begin
            active_d <= 1'b0;
            rgb      <= '0;
            de       <= 1'b0;
        end else if (cen) begin
            active_d <= active;
            // channel 0 red, 1 green, 2 blue
            rgb.r <= chan[0];
            rgb.g <= chan[1];
            rgb.b <= chan[2];
            de    <= active_d;
        end
    end

    // display enable only moves on pixel ticks
    de_rise_on_cen: assert property (
        @(posedge clk) disable iff (reset)
        $rose(de) |-> $past(cen)
    );

endmodule

// File: colour_mixer.sv
// ----------------------------------------
// three cen ticks from pixel in to rgb out
// PROMs must be loaded before use
// ----------------------------------------
`timescale 1ns/1ps

module colour_mixer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cen,       // pixel strobe in clk domain
    input  colmix_pkg::layer_pxl_t                pxl,
    input  colmix_pkg::layer_en_t                 layer_en,
    input  logic                                 hblank,
    input  logic                                 vblank,
    input  logic [colmix_pkg::pal_addr_w-1:0]    prog_addr,
    input  logic [colmix_pkg::colour_w-1:0]      prog_data,
    input  logic [colmix_pkg::num_channels-1:0]  prog_we,   // 0 red, 1 green, 2 blue
    output colmix_pkg::rgb_t                      rgb,
    output logic                                 de
);

    colmix_pkg::pal_addr_u           pal_addr;
    logic                           active;
    logic [colmix_pkg::colour_w-1:0] chan [colmix_pkg::num_channels];

    pixel_priority pixel_priority_i (
        .clk      (clk),
        .reset    (reset),
        .cen      (cen),
        .pxl      (pxl),
        .layer_en (layer_en),
        .hblank   (hblank),
        .vblank   (vblank),
        .pal_addr (pal_addr),
        .active   (active)
    );

    // one PROM per colour channel, shared address and load bus
    for (genvar i = 0; i < colmix_pkg::num_channels; i++) begin : gen_prom
        palette_prom palette_prom_i (
            .clk     (clk),
            .cen     (cen),
            .rd_addr (pal_addr),
            .wr_addr (prog_addr),
            .wr_data (prog_data),
            .we      (prog_we[i]),
            .q       (chan[i])
        );
    end

    video_out video_out_i (
        .clk    (clk),
        .reset  (reset),
        .cen    (cen),
        .chan   (chan),
        .active (active),
        .rgb    (rgb),
        .de     (de)
    );

endmodule

// File: tb_colour_mixer.sv
// ----------------------------------------
// PROMs loaded with random data before use
// cen strobes one clk in four; inputs change on falling edge
// ----------------------------------------
`timescale 1ns/1ps

module tb_colour_mixer;

    localparam int tick_timeout = 16; // clk cycles allowed between ticks
    localparam int num_stream   = 60;
    localparam colmix_pkg::layer_en_t en_all = 3'b111; // char, scr, obj

    logic                                clk;
    logic                                reset;
    logic                                cen;
    colmix_pkg::layer_pxl_t              pxl;
    colmix_pkg::layer_en_t               layer_en;
    logic                                hblank;
    logic                                vblank;
    logic [colmix_pkg::pal_addr_w-1:0]   prog_addr;
    logic [colmix_pkg::colour_w-1:0]     prog_data;
    logic [colmix_pkg::num_channels-1:0] prog_we;
    colmix_pkg::rgb_t                    rgb;
    logic                                de;

    logic [1:0]       cen_cnt;    // clk divider for the pixel strobe
    int               errors;
    int               checks;
    int unsigned      seed_ret;
    colmix_pkg::rgb_t pal [256];  // model copy of the three PROMs

    colour_mixer colour_mixer_i (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .pxl       (pxl),
        .layer_en  (layer_en),
        .hblank    (hblank),
        .vblank    (vblank),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .rgb       (rgb),
        .de        (de)
    );

    always #2 clk = ~clk; // 4 ns period

    // pixel strobe, high one clk in four
    always @(negedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        cen     <= (cen_cnt == 2'd3);
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = %0h, expected %0h (t=%0t)", name, actual, expected, $time);
        end
    endtask

    // next pixel tick, returns on the falling edge after it
    task automatic wait_tick();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cen && cycles < tick_timeout);
        if (!cen) begin
            $display("timeout: no pixel clock enable seen in %0d clk cycles", tick_timeout);
            $display("Done: errors found");
            $finish;
        end
        @(negedge clk); // outputs settled here
    endtask

    // palette address from the priority rule
    function automatic logic [7:0] model_addr(input colmix_pkg::layer_pxl_t p,
                                              input colmix_pkg::layer_en_t en,
                                              input logic hb, input logic vb);
        logic       c_op;
        logic       o_op;
        logic [5:0] low;
        c_op = (p.char_pxl != 4'hf); // all ones is see-through
        o_op = (p.obj_pxl != 4'hf);
        if (c_op && en.char_en)
            low = {p.bank, 1'b0, p.char_pxl};
        else if (o_op && en.obj_en)
            low = {1'b0, p.bank, p.obj_pxl};
        else if (en.scr_en)
            low = p.scr_pxl;
        else
            low = 6'h3f; // scroll hidden
        if (hb || vb)
            return 8'h00;
        return {c_op, o_op, low}; // raw flags, enables ignored
    endfunction

    function automatic colmix_pkg::layer_pxl_t make_pixel(input logic [3:0] c,
                                                          input logic [5:0] s,
                                                          input logic [3:0] o,
                                                          input logic b);
        colmix_pkg::layer_pxl_t p;
        p.char_pxl = c;
        p.scr_pxl  = s;
        p.obj_pxl  = o;
        p.bank     = b;
        return p;
    endfunction

    // one pixel in, three ticks, compare colour and enable
    task automatic drive_and_check(input colmix_pkg::layer_pxl_t p,
                                   input colmix_pkg::layer_en_t en,
                                   input logic hb, input logic vb);
        logic [7:0] a;
        a        = model_addr(p, en, hb, vb);
        pxl      = p;
        layer_en = en;
        hblank   = hb;
        vblank   = vb;
        repeat (3) wait_tick();
        check("rgb", rgb, pal[a]);
        check("de", de, !(hb || vb));
    endtask

    task automatic load_palettes();
        logic [3:0] d;
        for (int ch = 0; ch < 3; ch++) begin
            for (int a = 0; a < 256; a++) begin
                d         = $urandom_range(15, 0);
                prog_addr = a;
                prog_data = d;
                prog_we   = 3'b001 << ch; // one strobe per channel
                if (ch == 0)
                    pal[a].r = d;
                else if (ch == 1)
                    pal[a].g = d;
                else
                    pal[a].b = d;
                @(negedge clk);
            end
        end
        prog_we = '0;
        wait_tick(); // back in step with the pixel clock
        // scroll-only pixels, flags zero, so address = scroll code
        for (int a = 0; a < 64; a++)
            drive_and_check(make_pixel(4'hf, a, 4'hf, 1'b0), en_all, 1'b0, 1'b0);
    endtask

    task automatic char_priority();
        for (int i = 0; i < 8; i++)
            drive_and_check(make_pixel($urandom_range(14, 0), $urandom_range(63, 0),
                                       $urandom_range(15, 0), $urandom_range(1, 0)),
                            en_all, 1'b0, 1'b0);
    endtask

    task automatic obj_over_scroll();
        for (int i = 0; i < 8; i++)
            drive_and_check(make_pixel(4'hf, $urandom_range(63, 0),
                                       $urandom_range(14, 0), $urandom_range(1, 0)),
                            en_all, 1'b0, 1'b0);
        // both sprites see-through
        for (int i = 0; i < 4; i++)
            drive_and_check(make_pixel(4'hf, $urandom_range(63, 0), 4'hf,
                                       $urandom_range(1, 0)), en_all, 1'b0, 1'b0);
    endtask

    task automatic layer_enables();
        drive_and_check(make_pixel(4'h3, 6'h15, 4'h9, 1'b1), 3'b011, 1'b0, 1'b0); // char off
        drive_and_check(make_pixel(4'h3, 6'h15, 4'h9, 1'b0), 3'b010, 1'b0, 1'b0); // scr only
        drive_and_check(make_pixel(4'hf, 6'h2a, 4'hf, 1'b0), 3'b101, 1'b0, 1'b0); // scr off
        drive_and_check(make_pixel(4'h7, 6'h2a, 4'h1, 1'b1), 3'b101, 1'b0, 1'b0);
        drive_and_check(make_pixel(4'h5, 6'h0c, 4'hf, 1'b1), 3'b000, 1'b0, 1'b0); // all off
    endtask

    task automatic blanking();
        drive_and_check(make_pixel(4'h2, 6'h11, 4'h4, 1'b1), en_all, 1'b1, 1'b0);
        drive_and_check(make_pixel(4'hf, 6'h23, 4'h8, 1'b0), en_all, 1'b0, 1'b1);
        drive_and_check(make_pixel(4'hf, 6'h3e, 4'hf, 1'b1), en_all, 1'b1, 1'b1);
        drive_and_check(make_pixel(4'h2, 6'h11, 4'h4, 1'b1), en_all, 1'b0, 1'b0); // back on
    endtask

    // new pixel every tick, output lags three ticks
    task automatic stream();
        colmix_pkg::layer_pxl_t p;
        colmix_pkg::layer_en_t  en;
        logic                   hb;
        logic [7:0]             a;
        colmix_pkg::rgb_t       exp_rgb [$];
        logic                   exp_de [$];
        for (int i = 0; i < num_stream + 3; i++) begin
            if (i < num_stream) begin
                p  = make_pixel($urandom_range(15, 0), $urandom_range(63, 0),
                                $urandom_range(15, 0), $urandom_range(1, 0));
                en = $urandom_range(7, 0);
                hb = ($urandom_range(7, 0) == 0); // occasional blank
                a  = model_addr(p, en, hb, 1'b0);
                pxl      = p;
                layer_en = en;
                hblank   = hb;
                vblank   = 1'b0;
                exp_rgb.push_back(pal[a]);
                exp_de.push_back(!hb);
            end
            if (i >= 3) begin
                check("rgb", rgb, exp_rgb.pop_front());
                check("de", de, exp_de.pop_front());
            end
            wait_tick();
        end
    endtask

    initial begin
        seed_ret  = $urandom(32'h6d18641d);
        clk       = 1'b0;
        reset     = 1'b1;
        cen       = 1'b0;
        cen_cnt   = 2'd0;
        pxl       = '0;
        layer_en  = en_all;
        hblank    = 1'b0;
        vblank    = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = '0;
        errors    = 0;
        checks    = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check("rgb", rgb, 12'h000); // reset values
        check("de", de, 1'b0);
        wait_tick();
        load_palettes();
        char_priority();
        obj_over_scroll();
        layer_enables();
        blanking();
        stream();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: tb.f
colmix_pkg.sv
pixel_priority.sv
palette_prom.sv
video_out.sv
colour_mixer.sv
tb_colour_mixer.sv

// File: Bender.yml
package:
  name: colour_mixer

sources:
  - colmix_pkg.sv
  - pixel_priority.sv
  - palette_prom.sv
  - video_out.sv
  - colour_mixer.sv
  - target: test
    files:
      - tb_colour_mixer.sv
